// File: vlog.f
verilog/enc_mat_pkg.sv
verilog/coef_bank.sv
verilog/mul_array.sv
verilog/sum_array.sv
verilog/enc_multiplicator.sv
verilog/enc_transform_top.sv
verif/tb_enc_transform.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the transform engine testbench with Verilator.
# Exit status is nonzero when the build fails or the testbench fails.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=sim_tb

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_enc_transform \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_EXE" \
    -f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/$SIM_EXE"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// File: verif/tb_enc_transform.sv
/*
 * Testbench for the 4x4 transform engine.
 * Runs a hand-written table of matrices and vectors, a back-to-back burst,
 * and a random phase checked against a reference model of the row rule.
 */

`timescale 1ns/1ps

module tb_enc_transform
    import enc_mat_pkg::*;
();

    localparam int NUM_CASES   = 6;
    localparam int WAIT_LIMIT  = 20;
    localparam int RAND_COUNT  = 200;
    localparam int RAND_CYCLES = 5000;

    logic       clk;
    logic       reset;
    logic       coef_we;
    coef_addr_t coef_addr;
    coef_t      coef_data;
    logic       in_valid;
    vec_t       in_vec;
    logic       out_valid;
    sum_vec_t   out_sum;
    carry_vec_t out_carry;

    // table, row and vector words list column 0 in the top byte
    string       case_name  [NUM_CASES];
    logic [31:0] case_rows  [NUM_CASES][N_LANES];
    logic [31:0] case_vec   [NUM_CASES];
    sum_vec_t    case_sum   [NUM_CASES];
    carry_vec_t  case_carry [NUM_CASES];

    // expected results in issue order
    sum_vec_t   exp_sum_q   [$];
    carry_vec_t exp_carry_q [$];
    string      exp_name_q  [$];

    // coefficients as the DUT holds them after the last edge
    coef_t       model_mat [N_LANES][N_LANES];
    logic [1:0]  valid_pipe;
    logic [31:0] rng;
    string       phase;

    enc_transform_top enc_transform_top_i (
        .clk       (clk),
        .reset     (reset),
        .coef_we   (coef_we),
        .coef_addr (coef_addr),
        .coef_data (coef_data),
        .in_valid  (in_valid),
        .in_vec    (in_vec),
        .out_valid (out_valid),
        .out_sum   (out_sum),
        .out_carry (out_carry)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic vec_t word_to_vec(input logic [31:0] w);
        vec_t v;
        for (int j = 0; j < N_LANES; j++) begin
            v[j] = w[31-8*j -: 8];
        end
        return v;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_sum(input string name, input int row,
                             input sum_t expected, input sum_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("CHECK FAILED %s out_sum[%0d]: expected %0d actual %0d",
                                name, row, expected, actual));
        end
    endtask

    task automatic check_carry(input string name, input int row,
                               input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_stop($sformatf("CHECK FAILED %s out_carry[%0d]: expected %0b actual %0b",
                                name, row, expected, actual));
        end
    endtask

    task automatic check_idle(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_stop($sformatf("CHECK FAILED %s out_valid: expected %0b actual %0b",
                                name, expected, actual));
        end
    endtask

    task automatic add_case(input int idx, input string name,
                            input logic [31:0] r0, input logic [31:0] r1,
                            input logic [31:0] r2, input logic [31:0] r3,
                            input logic [31:0] v,
                            input sum_t s0, input sum_t s1, input sum_t s2, input sum_t s3,
                            input carry_vec_t c);
        case_name[idx]    = name;
        case_rows[idx][0] = r0;
        case_rows[idx][1] = r1;
        case_rows[idx][2] = r2;
        case_rows[idx][3] = r3;
        case_vec[idx]     = v;
        case_sum[idx][0]  = s0;
        case_sum[idx][1]  = s1;
        case_sum[idx][2]  = s2;
        case_sum[idx][3]  = s3;
        case_carry[idx]   = c;
    endtask

    // row i: sum over j of coef[i][j] * v[j], carry when it reaches 65536
    task automatic push_model(input vec_t v, input string name);
        sum_vec_t    s;
        carry_vec_t  c;
        int unsigned acc;
        for (int i = 0; i < N_LANES; i++) begin
            acc = 0;
            for (int j = 0; j < N_LANES; j++) begin
                acc = acc + int'(model_mat[i][j]) * int'(v[j]);
            end
            s[i] = acc[SUM_W-1:0];
            c[i] = (acc >= 32'd65536);
        end
        exp_sum_q.push_back(s);
        exp_carry_q.push_back(c);
        exp_name_q.push_back(name);
    endtask

    task automatic check_outputs();
        string      name;
        sum_vec_t   es;
        carry_vec_t ec;
        // out_valid mirrors in_valid driven two falling edges back
        check_idle(phase, valid_pipe[1], out_valid);
        if (out_valid) begin
            if (exp_name_q.size() == 0) begin
                fail_stop("out_valid went high with no result expected");
            end
            name = exp_name_q.pop_front();
            es   = exp_sum_q.pop_front();
            ec   = exp_carry_q.pop_front();
            for (int i = 0; i < N_LANES; i++) begin
                check_sum(name, i, es[i], out_sum[i]);
                check_carry(name, i, ec[i], out_carry[i]);
            end
        end
    endtask

    // one clock: check outputs, then drive the next inputs
    task automatic drive(input logic wr_en, input coef_addr_t wr_addr, input coef_t wr_data,
                         input logic smp_valid, input vec_t smp_vec);
        @(negedge clk);
        check_outputs();
        coef_we   = wr_en;
        coef_addr = wr_addr;
        coef_data = wr_data;
        in_valid  = smp_valid;
        in_vec    = smp_vec;
        // row in the upper two address bits
        if (wr_en) begin
            model_mat[wr_addr[3:2]][wr_addr[1:0]] = wr_data;
        end
        valid_pipe = {valid_pipe[0], smp_valid};
    endtask

    task automatic idle_cycle();
        drive(1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic wait_drain(input string name);
        int cnt;
        cnt = 0;
        while (exp_name_q.size() > 0) begin
            if (cnt >= WAIT_LIMIT) begin
                fail_stop($sformatf("timeout: out_valid missing for %0d cycles in %s",
                                    WAIT_LIMIT, name));
            end
            idle_cycle();
            cnt++;
        end
    endtask

    initial begin
        int          sent;
        int          cycles;
        logic        wr_en;
        logic        smp_valid;
        coef_addr_t  wr_addr;
        coef_t       wr_data;
        vec_t        v;

        reset      = 1'b1;
        coef_we    = 1'b0;
        coef_addr  = '0;
        coef_data  = '0;
        in_valid   = 1'b0;
        in_vec     = '0;
        valid_pipe = '0;
        rng        = 32'h5249;
        phase      = "reset";
        for (int i = 0; i < N_LANES; i++) begin
            for (int j = 0; j < N_LANES; j++) begin
                model_mat[i][j] = '0;
            end
        end

        // carries listed row 3 down to row 0
        add_case(0, "identity", 32'h01000000, 32'h00010000, 32'h00000100, 32'h00000001,
                 32'h0A141E28, 16'd10, 16'd20, 16'd30, 16'd40, 4'b0000);
        add_case(1, "all_ones", 32'h01010101, 32'h01010101, 32'h01010101, 32'h01010101,
                 32'h0A141E28, 16'd100, 16'd100, 16'd100, 16'd100, 4'b0000);
        add_case(2, "all_max", 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF,
                 32'hFFFFFFFF, 16'd63492, 16'd63492, 16'd63492, 16'd63492, 4'b1111);
        add_case(3, "exact_65535", 32'hFF020000, 32'hFF030000, 32'h80800100, 32'h00000000,
                 32'hFFFFFFFF, 16'd65535, 16'd254, 16'd65535, 16'd0, 4'b0010);
        add_case(4, "row_order", 32'h02010101, 32'h01020101, 32'h01010201, 32'h01010102,
                 32'h01020304, 16'd11, 16'd12, 16'd13, 16'd14, 4'b0000);
        add_case(5, "mixed", 32'h10203040, 32'h00FF0000, 32'h03000000, 32'h0000000A,
                 32'h05060708, 16'd1120, 16'd1530, 16'd15, 16'd80, 4'b0000);

        repeat (4) @(negedge clk);
        reset = 1'b0;

        // idle after reset, then a sample against the cleared matrix
        phase = "reset_zero";
        repeat (5) idle_cycle();
        exp_sum_q.push_back('0);
        exp_carry_q.push_back('0);
        exp_name_q.push_back("reset_zero");
        drive(1'b0, '0, '0, 1'b1, word_to_vec(32'h0A141E28));
        wait_drain("reset_zero");

        phase = "table";
        for (int k = 0; k < NUM_CASES; k++) begin
            for (int i = 0; i < N_LANES; i++) begin
                for (int j = 0; j < N_LANES; j++) begin
                    drive(1'b1, coef_addr_t'(i * N_LANES + j),
                          case_rows[k][i][31-8*j -: 8], 1'b0, '0);
                end
            end
            exp_sum_q.push_back(case_sum[k]);
            exp_carry_q.push_back(case_carry[k]);
            exp_name_q.push_back(case_name[k]);
            drive(1'b0, '0, '0, 1'b1, word_to_vec(case_vec[k]));
            wait_drain(case_name[k]);
        end

        // burst of four, a gap, then two samples one cycle apart
        phase = "back_to_back";
        for (int n = 0; n < 4; n++) begin
            v = word_to_vec(32'h11223344 + 32'h01010101 * n);
            push_model(v, "back_to_back");
            drive(1'b0, '0, '0, 1'b1, v);
        end
        repeat (3) idle_cycle();
        v = word_to_vec(32'hFF00FF00);
        push_model(v, "back_to_back");
        drive(1'b0, '0, '0, 1'b1, v);
        idle_cycle();
        push_model(v, "back_to_back");
        drive(1'b0, '0, '0, 1'b1, v);
        wait_drain("back_to_back");

        // writes and samples mixed, sometimes on the same edge
        phase  = "random";
        sent   = 0;
        cycles = 0;
        while (sent < RAND_COUNT) begin
            if (cycles >= RAND_CYCLES) begin
                fail_stop("random phase ran out of cycles before all samples were sent");
            end
            rng       = xorshift32(rng);
            wr_en     = (rng[1:0] != 2'b00);
            smp_valid = rng[2];
            wr_addr   = coef_addr_t'(rng[7:4]);
            wr_data   = rng[15:8];
            rng       = xorshift32(rng);
            v         = word_to_vec(rng);
            if (smp_valid) begin
                push_model(v, "random");
                sent++;
            end
            drive(wr_en, wr_addr, wr_data, smp_valid, v);
            cycles++;
        end
        wait_drain("random");

        phase = "final_idle";
        repeat (5) idle_cycle();

        $display("test passed");
        $finish;
    end

endmodule

// File: verilog/enc_transform_top.sv
/*
 * Top level of the 4x4 transform engine.
 * The host loads coefficients through coef_we/coef_addr/coef_data, then
 * streams vectors with in_valid; each gives four sums and carries two
 * cycles later on out_valid. No back-pressure, outputs are not held.
 */

`timescale 1ns/1ps

module enc_transform_top
    import enc_mat_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // coefficient load port
    input  logic       coef_we,
    input  coef_addr_t coef_addr,
    input  coef_t      coef_data,

    // sample input
    input  logic       in_valid,
    input  vec_t       in_vec,

    // result output
    output logic       out_valid,
    output sum_vec_t   out_sum,
    output carry_vec_t out_carry
);

    coef_mat_t coef_mat;

    coef_bank coef_bank_i (
        .clk       (clk),
        .reset     (reset),
        .coef_we   (coef_we),
        .coef_addr (coef_addr),
        .coef_data (coef_data),
        .coef_mat  (coef_mat)
    );

    // samples see the matrix as it stood before their capture edge
    enc_multiplicator enc_multiplicator_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_vec    (in_vec),
        .coef_mat  (coef_mat),
        .out_valid (out_valid),
        .out_sum   (out_sum),
        .out_carry (out_carry)
    );

endmodule

// File: verilog/enc_multiplicator.sv
/*
 * Matrix-by-vector datapath: sixteen multipliers feeding four adders.
 * Two register stages, so results appear two cycles after in_valid.
 * Kept as a standalone block so a second transform pass can reuse it.
 */

`timescale 1ns/1ps

module enc_multiplicator
    import enc_mat_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  vec_t       in_vec,
    input  coef_mat_t  coef_mat,
    output logic       out_valid,
    output sum_vec_t   out_sum,
    output carry_vec_t out_carry
);

    // products between the two stages
    logic      prod_valid;
    prod_mat_t prod;

    // stage 1, coef[i][j] * in_vec[j]
    mul_array mul_array_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_vec     (in_vec),
        .coef_mat   (coef_mat),
        .prod_valid (prod_valid),
        .prod       (prod)
    );

    // stage 2, one adder per row
    sum_array sum_array_i (
        .clk        (clk),
        .reset      (reset),
        .prod_valid (prod_valid),
        .prod       (prod),
        .out_valid  (out_valid),
        .out_sum    (out_sum),
        .out_carry  (out_carry)
    );

endmodule

// File: verilog/sum_array.sv
/*
 * Second pipeline stage of the matrix-vector datapath.
 * Each row's four products are added at full width; the low 16 bits are
 * registered as the sum and any higher bit as the overflow carry.
 * out_valid follows prod_valid by one cycle.
 */

`timescale 1ns/1ps

module sum_array
    import enc_mat_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       prod_valid,
    input  prod_mat_t  prod,
    output logic       out_valid,
    output sum_vec_t   out_sum,
    output carry_vec_t out_carry
);

    logic [ACC_W-1:0] row_acc [N_LANES];

    // full-width row sums cannot overflow at ACC_W
    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            row_acc[i] = '0;
            for (int j = 0; j < N_LANES; j++) begin
                row_acc[i] = row_acc[i] + ACC_W'(prod[i][j]);
            end
        end
    end

    // sum keeps the low bits
    // carry flags anything that did not fit
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_LANES; i++) begin
            out_sum[i]   <= row_acc[i][SUM_W-1:0];
            out_carry[i] <= |row_acc[i][ACC_W-1:SUM_W];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= prod_valid;
        end
    end

    // the result presented one cycle after prod_valid must be fully known
    property p_result_known;
        @(posedge clk) disable iff (reset)
            prod_valid |=> !$isunknown({out_sum, out_carry});
    endproperty

    a_result_known: assert property (p_result_known)
        else $error("sum_array: unknown result one cycle after prod_valid");

endmodule

// File: verilog/mul_array.sv
/*
 * First pipeline stage of the matrix-vector datapath.
 * Sixteen registered multipliers form coef[i][j] * sample[j] every cycle;
 * prod_valid follows in_valid by one cycle.
 */

`timescale 1ns/1ps

module mul_array
    import enc_mat_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  vec_t      in_vec,
    input  coef_mat_t coef_mat,
    output logic      prod_valid,
    output prod_mat_t prod
);

    wire prod_mat_t prod_next;

    // one multiplier per matrix entry, sample j shared down column j
    for (genvar i = 0; i < N_LANES; i++) begin : g_row
        for (genvar j = 0; j < N_LANES; j++) begin : g_col
            assign prod_next[i][j] = PROD_W'(coef_mat[i][j]) * PROD_W'(in_vec[j]);
        end
    end

    // products registered every cycle, only valid qualifies them
    always_ff @(posedge clk) begin
        prod <= prod_next;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
        end
    end

    // the adder stage and the output strobe depend on a clean valid;
    // an X here would spread into out_valid downstream
    property p_valid_known;
        @(posedge clk) disable iff (reset)
            !$isunknown(prod_valid);
    endproperty

    a_valid_known: assert property (p_valid_known)
        else $error("mul_array: prod_valid unknown after reset");

endmodule

// File: verilog/coef_bank.sv
/*
 * Coefficient storage for the transform engine.
 * The host writes one matrix entry per coef_we strobe; the full matrix is
 * presented on coef_mat one cycle later. Reset clears every entry to zero.
 */

`timescale 1ns/1ps

module coef_bank
    import enc_mat_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       coef_we,
    input  coef_addr_t coef_addr,
    input  coef_t      coef_data,
    output coef_mat_t  coef_mat
);

    logic [LANE_IDX_W-1:0] wr_row;
    logic [LANE_IDX_W-1:0] wr_col;

    // address is row in the upper bits, column in the lower bits
    assign wr_row = coef_addr[2*LANE_IDX_W-1:LANE_IDX_W];
    assign wr_col = coef_addr[LANE_IDX_W-1:0];

    // one entry per strobe, the rest hold
    always_ff @(posedge clk) begin
        if (reset) begin
            coef_mat <= '0;
        end else if (coef_we) begin
            coef_mat[wr_row][wr_col] <= coef_data;
        end
    end

    // a write with an unknown address would corrupt an unknown entry
    // and poison every later sample through the datapath
    property p_addr_known;
        @(posedge clk) disable iff (reset)
            coef_we |-> !$isunknown(coef_addr);
    endproperty

    a_addr_known: assert property (p_addr_known)
        else $error("coef_bank: coef_we high with unknown coef_addr");

endmodule

// File: verilog/enc_mat_pkg.sv
/*
 * Shared sizes and data types for the 4x4 matrix-by-vector transform engine.
 * Every RTL module imports this package; vectors, matrices and sums travel
 * between modules as the packed arrays declared here.
 */

package enc_mat_pkg;

    // matrix dimension and vector length
    localparam int N_LANES = 4;

    // coefficient and sample width
    localparam int DATA_W = 8;

    // an 8x8 unsigned product always fits here
    localparam int PROD_W = 16;

    // width of each output sum
    localparam int SUM_W = 16;

    // index width of one row or one column
    localparam int LANE_IDX_W = $clog2(N_LANES);

    // adder width, wide enough for the full sum of four products
    localparam int ACC_W = PROD_W + $clog2(N_LANES);

    typedef logic [DATA_W-1:0] sample_t;
    typedef logic [DATA_W-1:0] coef_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [SUM_W-1:0]  sum_t;

    // matrix entry index, row * 4 + column
    typedef logic [2*LANE_IDX_W-1:0] coef_addr_t;

    // input vector, element j
    typedef sample_t [N_LANES-1:0] vec_t;

    // coefficient matrix, [row][column]
    typedef coef_t [N_LANES-1:0][N_LANES-1:0] coef_mat_t;

    // products, [row][column]
    typedef prod_t [N_LANES-1:0][N_LANES-1:0] prod_mat_t;

    // one sum and one carry per row
    typedef sum_t [N_LANES-1:0] sum_vec_t;
    typedef logic [N_LANES-1:0] carry_vec_t;

endpackage
